// File: sim.f
source/ddr2_pkg.sv
source/ddr2_req_capture.sv
source/ddr2_req_fifo.sv
source/ddr2_refresh_timer.sv
source/ddr2_cmd_seq.sv
source/ddr2_ctrl_top.sv
dv/tb_clock.sv
dv/ddr2_bus_checker.sv
dv/ddr2_ctrl_tb.sv

// File: dv/ddr2_ctrl_tb.sv
`timescale 1ns/1ns

module ddr2_ctrl_tb import ddr2_pkg::*; ();

    localparam int N_REQ       = 200;
    localparam int WATCHDOG_NS = (N_REQ * 70 + 3 * T_REFI) * 40;
    localparam int DRAIN_CYC   = (FIFO_DEPTH + 2) * 70;

    logic                      clk;
    logic                      rst_n;
    logic                      req_valid;
    logic                      req_write;
    logic [HOST_ADDR_BITS-1:0] req_addr;
    logic [3:0]                req_beats_m1;
    logic                      req_ready;
    ddr2_bus_t                 ddr2_bus;
    logic                      end_of_test;
    logic                      drained;
    logic                      report_done;
    int                        fail_count;
    logic [31:0]               seed;

    tb_clock clock_gen (.clk, .rst_n);

    ddr2_ctrl_top ddr2_ctrl_top_inst (
        .clk, .rst_n, .req_valid, .req_write, .req_addr, .req_beats_m1,
        .req_ready, .ddr2_bus
    );

    ddr2_bus_checker bus_checker (
        .clk, .rst_n, .ddr2_bus, .req_valid, .req_ready, .req_write, .req_addr,
        .req_beats_m1, .end_of_test, .drained, .report_done, .fail_count
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    // hold the request until the handshake edge
    task automatic send_request(input logic wr, input logic [HOST_ADDR_BITS-1:0] addr,
                                input logic [3:0] beats);
        req_valid    <= 1'b1;
        req_write    <= wr;
        req_addr     <= addr;
        req_beats_m1 <= beats;
        @(posedge clk);
        while (!req_ready) begin
            @(posedge clk);  // back-pressure from a full queue
        end
        req_valid <= 1'b0;
    endtask

    task automatic send_random_request(input int n);
        logic [31:0] r1;
        logic [31:0] r2;
        int          gap;
        seed = lcg_next(seed);
        r1   = seed;
        seed = lcg_next(seed);
        r2   = seed;
        gap  = (n % 25 < 8) ? 0 : int'(r2[15:14]);  // gap-free runs fill the FIFO
        repeat (gap) @(posedge clk);
        send_request(r1[20], {r1[31:21], r2[31:16]}, r1[19:16]);
    endtask

    // --------------------
    // stimulus and verdict
    // --------------------
    initial begin
        seed         = 32'd7;
        req_valid    = 1'b0;
        req_write    = 1'b0;
        req_addr     = '0;
        req_beats_m1 = '0;
        end_of_test  = 1'b0;
        wait (rst_n === 1'b1);
        @(posedge clk);
        for (int n = 0; n < N_REQ; n++) begin
            send_random_request(n);
        end
        @(posedge clk);  // last handshake reaches the checker
        for (int i = 0; i < DRAIN_CYC && !drained; i++) begin
            @(posedge clk);
        end
        end_of_test <= 1'b1;
        wait (report_done === 1'b1);
        @(negedge clk);
        if (fail_count == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    // watchdog
    initial begin
        #(WATCHDOG_NS);
        $display("watchdog: run did not finish within %0d ns, the bus stalled", WATCHDOG_NS);
        $display("TEST FAILED");
        $finish;
    end

endmodule

// File: dv/ddr2_bus_checker.sv
`timescale 1ns/1ns

module ddr2_bus_checker import ddr2_pkg::*; (
    input  logic                      clk,
    input  logic                      rst_n,
    input  ddr2_bus_t                 ddr2_bus,
    input  logic                      req_valid,
    input  logic                      req_ready,
    input  logic                      req_write,
    input  logic [HOST_ADDR_BITS-1:0] req_addr,
    input  logic [3:0]                req_beats_m1,
    input  logic                      end_of_test,
    output logic                      drained,
    output logic                      report_done,
    output int                        fail_count
);

    // longest request from ACT back to IDLE, plus slack
    localparam int MAX_REQ_CYC = T_RCD + 2 * 15 + WR_TO_PRE + T_RP + 4;

    typedef struct packed {
        logic [15:0] id;
        logic        is_write;
        logic [2:0]  ba;
        logic [13:0] row;
        logic [9:0]  col;       // word column, four-word aligned
        logic [3:0]  beats_m1;
    } exp_req_t;

    exp_req_t ref_q [$];  // accepted, not yet activated
    exp_req_t cur;        // request with the open row
    logic     in_row;
    logic     exp_hold;   // capture register occupied
    int       pending;    // accepted and not yet popped by the sequencer
    int       errors [5];
    int       cyc;
    int       n_col;
    int       next_id;
    int       completed;
    int       act_cyc;
    int       col_cyc;
    int       pre_cyc;
    int       ref_cyc;
    int       rfc_end;    // only NOP up to here

    function automatic string test_name(input int t);
        case (t)
            0:       return "activate_addr";
            1:       return "column_sequence";
            2:       return "precharge_timing";
            3:       return "refresh_interval";
            default: return "order_and_completion";
        endcase
    endfunction

    task automatic report_value(input int t, input int exp_val, input int act_val,
                                input string what);
        errors[t]++;
        $display("FAILED %s %s expected %0d actual %0d (cycle %0d)",
                 test_name(t), what, exp_val, act_val, cyc);
    endtask

    task automatic report_text(input int t, input string msg);
        errors[t]++;
        $display("%s error at cycle %0d: %s", test_name(t), cyc, msg);
    endtask

    // --------------------
    // per-command checks
    // --------------------
    task automatic check_activate();
        exp_req_t exp_req;
        exp_req = '0;
        if (cyc - pre_cyc < T_RP) begin
            report_value(2, T_RP, cyc - pre_cyc, "min PRE to ACT gap");
        end
        if (in_row) begin
            report_text(0, "ACTIVATE while a row is still open");
        end
        if (ref_q.size() == 0) begin
            report_text(0, "ACTIVATE with no request pending");
        end else begin
            exp_req = ref_q.pop_front();
            if ({ddr2_bus.ba, ddr2_bus.addr.as_row} != {exp_req.ba, exp_req.row}) begin
                report_value(0, {exp_req.ba, exp_req.row},
                             {ddr2_bus.ba, ddr2_bus.addr.as_row}, "bank/row");
            end
        end
        cur     = exp_req;
        in_row  = 1'b1;
        n_col   = 0;
        act_cyc = cyc;
    endtask

    task automatic check_column();
        ddr2_cmd_e  exp_cmd;
        logic [9:0] exp_col;
        exp_cmd = cur.is_write ? WRITE : READ;
        exp_col = cur.col + 10'(n_col * 4);  // wraps inside the row
        if (!in_row) begin
            report_text(1, "column command with no open row");
        end else if (n_col > cur.beats_m1) begin
            report_text(1, "more column commands than bursts");
        end else begin
            if (ddr2_bus.cmd != exp_cmd) begin
                report_value(1, int'(exp_cmd), int'(ddr2_bus.cmd), "command");
            end
            if (ddr2_bus.ba != cur.ba) begin
                report_value(1, cur.ba, ddr2_bus.ba, "bank");
            end
            if (ddr2_bus.addr != {4'b0000, exp_col}) begin  // no auto precharge
                report_value(1, exp_col, ddr2_bus.addr, "column");
            end
            if (n_col == 0 && cyc - act_cyc != T_RCD) begin
                report_value(1, T_RCD, cyc - act_cyc, "ACT to first column gap");
            end
            if (n_col != 0 && cyc - col_cyc != 2) begin
                report_value(1, 2, cyc - col_cyc, "column spacing");
            end
        end
        n_col++;
        col_cyc = cyc;
    endtask

    task automatic check_precharge();
        int exp_gap;
        exp_gap = cur.is_write ? WR_TO_PRE : RD_TO_PRE;
        if (!in_row) begin
            report_text(2, "PRECHARGE with no open row");
        end else begin
            if (!ddr2_bus.addr.as_col.a10) begin
                report_text(2, "PRECHARGE without a10, not all banks");
            end
            if (cyc - col_cyc != exp_gap) begin
                report_value(2, exp_gap, cyc - col_cyc, "last column to PRE gap");
            end
            if (n_col != cur.beats_m1 + 1) begin
                report_value(1, cur.beats_m1 + 1, n_col, "column count");
            end
            if (cur.id != completed) begin
                report_value(4, completed, cur.id, "completed request id");
            end
            completed++;
        end
        in_row  = 1'b0;
        pre_cyc = cyc;
    endtask

    task automatic check_refresh();
        if (in_row) begin
            report_text(3, "AUTO REFRESH between ACTIVATE and PRECHARGE");
        end
        if (cyc - pre_cyc < T_RP) begin
            report_value(2, T_RP, cyc - pre_cyc, "min PRE to REF gap");
        end
        if (cyc - ref_cyc > T_REFI + MAX_REQ_CYC) begin
            report_value(3, T_REFI + MAX_REQ_CYC, cyc - ref_cyc, "max refresh gap");
        end
        ref_cyc = cyc;
        rfc_end = cyc + T_RFC;
    endtask

    task automatic final_report();
        int lost;
        int n_fail;
        lost = ref_q.size() + (in_row ? 1 : 0);
        if (lost != 0) begin
            report_text(4, $sformatf("%0d of %0d requests were lost", lost, next_id));
        end
        if (cyc - ref_cyc > T_REFI + MAX_REQ_CYC) begin
            report_text(3, "no AUTO REFRESH within the last refresh interval");
        end
        n_fail = 0;
        for (int t = 0; t < 5; t++) begin
            $display("%-22s %s, %0d errors", test_name(t), errors[t] == 0 ? "pass" : "fail",
                     errors[t]);
            if (errors[t] != 0) begin
                n_fail++;
            end
        end
        $display("tests passed %0d, failed %0d, requests completed %0d of %0d",
                 5 - n_fail, n_fail, completed, next_id);
        fail_count  <= n_fail;
        report_done <= 1'b1;
    endtask

    // --------------------
    // bus monitor, samples values from before the edge
    // --------------------
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ref_q.delete();
            foreach (errors[t]) begin
                errors[t] = 0;
            end
            cur       = '0;
            in_row    = 1'b0;
            exp_hold  = 1'b0;
            pending   = 0;
            cyc       = 0;
            n_col     = 0;
            next_id   = 0;
            completed = 0;
            act_cyc   = -100;
            col_cyc   = -100;
            pre_cyc   = -100;
            ref_cyc   = 0;  // interval counts from reset
            rfc_end   = 0;
            drained     <= 1'b1;
            report_done <= 1'b0;
            fail_count  <= 0;
        end else begin
            cyc++;
            // an ACT on the bus means the queue was popped on the last edge
            pending = ref_q.size() - ((ddr2_bus.cmd == ACT) ? 1 : 0);
            if (req_ready !== !exp_hold) begin
                report_value(4, int'(!exp_hold), int'(req_ready), "req_ready");
            end
            if (req_valid && req_ready) begin
                ref_q.push_back('{id: 16'(next_id), is_write: req_write,
                                  ba: req_addr[26:24], row: req_addr[23:10],
                                  col: {req_addr[9:2], 2'b00}, beats_m1: req_beats_m1});
                next_id++;
                exp_hold = 1'b1;
            end else if (exp_hold && pending - 1 < FIFO_DEPTH) begin
                exp_hold = 1'b0;  // moves on into the queue
            end
            if (ddr2_bus.cmd != NOP && cyc <= rfc_end) begin
                report_text(3, "command inside tRFC after AUTO REFRESH");
            end
            case (ddr2_bus.cmd)
                NOP:         ;
                ACT:         check_activate();
                WRITE, READ: check_column();
                PRE:         check_precharge();
                AREF:        check_refresh();
                default:     report_text(1, "unknown command code on the bus");
            endcase
            drained <= (ref_q.size() == 0) && !in_row;
            if (end_of_test && !report_done) begin
                final_report();
            end
        end
    end

endmodule

// File: dv/tb_clock.sv
`timescale 1ns/1ns

module tb_clock (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;  // 40 ns period
    end

    initial begin
        rst_n = 1'b0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;  // release away from the rising edge
    end

endmodule

// File: source/ddr2_ctrl_top.sv
`timescale 1ns/1ns

module ddr2_ctrl_top import ddr2_pkg::*; (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      req_valid,
    input  logic                      req_write,
    input  logic [HOST_ADDR_BITS-1:0] req_addr,
    input  logic [3:0]                req_beats_m1,
    output logic                      req_ready,
    output ddr2_bus_t                 ddr2_bus
);

    logic      push;
    logic      pop;
    logic      full;
    logic      empty;
    logic      ref_due;
    logic      ref_ack;
    ddr2_req_t push_req;
    ddr2_req_t head;

    ddr2_req_capture ddr2_req_capture_inst (
        .clk, .rst_n, .req_valid, .req_write, .req_addr, .req_beats_m1,
        .full, .req_ready, .push, .push_req
    );

    ddr2_req_fifo ddr2_req_fifo_inst (
        .clk, .rst_n, .push, .push_req, .pop, .head, .empty, .full
    );

    ddr2_refresh_timer ddr2_refresh_timer_inst (
        .clk, .rst_n, .ref_ack, .ref_due
    );

    ddr2_cmd_seq ddr2_cmd_seq_inst (
        .clk, .rst_n, .empty, .head, .ref_due, .pop, .ref_ack, .ddr2_bus
    );

endmodule

// File: source/ddr2_cmd_seq.sv
`timescale 1ns/1ns

module ddr2_cmd_seq import ddr2_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      empty,
    input  ddr2_req_t head,
    input  logic      ref_due,
    output logic      pop,
    output logic      ref_ack,
    output ddr2_bus_t ddr2_bus
);

    typedef enum logic [2:0] {
        IDLE,
        ACT_WAIT,
        BURST,
        RECOVER,
        PRE_WAIT,
        REF_WAIT
    } seq_state_e;

    typedef logic [$clog2(T_RFC)-1:0] wait_t;  // longest wait is tRFC

    seq_state_e           state;
    wait_t                wait_cnt;
    wait_t                rec_len;
    ddr2_req_t            cur_req;   // request being served
    logic [3:0]           beat_idx;  // bursts issued so far
    logic [COL_BITS-3:0]  col_word;
    ddr2_cmd_e            col_cmd;
    ddr2_addr_u           row_addr;
    ddr2_addr_u           col_addr;
    ddr2_addr_u           pre_addr;

    // refresh wins over a waiting request
    assign ref_ack = (state == IDLE) && ref_due;
    assign pop     = (state == IDLE) && !ref_due && !empty;

    // --------------------
    // command and address decode
    // --------------------
    always_comb begin
        col_word = cur_req.col_q + {4'b0000, beat_idx};
        col_cmd  = cur_req.is_write ? WRITE : READ;
        rec_len  = cur_req.is_write ? wait_t'(WR_TO_PRE - 1) : wait_t'(RD_TO_PRE - 1);

        row_addr        = '0;
        row_addr.as_row = head.row;

        col_addr            = '0;
        col_addr.as_col.col = {col_word, 2'b00};  // four-word aligned

        pre_addr            = '0;
        pre_addr.as_col.a10 = 1'b1;  // precharge all banks
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            cur_req <= head;
        end
    end

    // --------------------
    // sequencer FSM
    // --------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= IDLE;
            wait_cnt <= '0;
            beat_idx <= '0;
            ddr2_bus <= '{cmd: NOP, ba: '0, addr: '0};
        end else begin
            ddr2_bus.cmd <= NOP;  // ba and addr hold
            case (state)
                IDLE: begin
                    if (ref_due) begin
                        ddr2_bus.cmd <= AREF;
                        wait_cnt     <= wait_t'(T_RFC - 1);
                        state        <= REF_WAIT;
                    end else if (!empty) begin
                        ddr2_bus <= '{cmd: ACT, ba: head.ba, addr: row_addr};
                        wait_cnt <= wait_t'(T_RCD - 2);  // one more cycle spent entering BURST
                        beat_idx <= '0;
                        state    <= ACT_WAIT;
                    end
                end
                ACT_WAIT: begin
                    if (wait_cnt == '0) begin
                        state <= BURST;
                    end else begin
                        wait_cnt <= wait_cnt - 1'b1;
                    end
                end
                BURST: begin
                    if (wait_cnt == '0) begin
                        ddr2_bus <= '{cmd: col_cmd, ba: cur_req.ba, addr: col_addr};
                        beat_idx <= beat_idx + 1'b1;
                        if (beat_idx == cur_req.beats_m1) begin
                            wait_cnt <= rec_len;  // write or read recovery
                            state    <= RECOVER;
                        end else begin
                            wait_cnt <= wait_t'(1);  // next burst two cycles on
                        end
                    end else begin
                        wait_cnt <= wait_cnt - 1'b1;
                    end
                end
                RECOVER: begin
                    if (wait_cnt == '0) begin
                        ddr2_bus <= '{cmd: PRE, ba: cur_req.ba, addr: pre_addr};
                        wait_cnt <= wait_t'(T_RP - 1);
                        state    <= PRE_WAIT;
                    end else begin
                        wait_cnt <= wait_cnt - 1'b1;
                    end
                end
                PRE_WAIT, REF_WAIT: begin
                    if (wait_cnt == '0) begin
                        state <= IDLE;
                    end else begin
                        wait_cnt <= wait_cnt - 1'b1;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

endmodule

// File: source/ddr2_refresh_timer.sv
`timescale 1ns/1ns

module ddr2_refresh_timer import ddr2_pkg::*; (
    input  logic clk,
    input  logic rst_n,
    input  logic ref_ack,
    output logic ref_due
);

    typedef logic [$clog2(T_REFI)-1:0] refi_t;

    refi_t refi_cnt;
    logic  wrap;

    assign wrap = (refi_cnt == refi_t'(T_REFI - 1));

    // free running, restarts every T_REFI cycles
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            refi_cnt <= '0;
            ref_due  <= 1'b0;
        end else begin
            refi_cnt <= wrap ? '0 : refi_cnt + 1'b1;
            if (wrap) begin
                ref_due <= 1'b1;  // a pending one just stays set
            end else if (ref_ack) begin
                ref_due <= 1'b0;
            end
        end
    end

endmodule

// File: source/ddr2_req_fifo.sv
`timescale 1ns/1ns

module ddr2_req_fifo import ddr2_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      push,
    input  ddr2_req_t push_req,
    input  logic      pop,
    output ddr2_req_t head,
    output logic      empty,
    output logic      full
);

    typedef logic [$clog2(FIFO_DEPTH)-1:0]   ptr_t;
    typedef logic [$clog2(FIFO_DEPTH+1)-1:0] cnt_t;

    ddr2_req_t mem [FIFO_DEPTH];
    ptr_t      wr_ptr;
    ptr_t      rd_ptr;
    cnt_t      count;  // occupancy

    assign head  = mem[rd_ptr];
    assign empty = (count == '0);
    assign full  = (count == cnt_t'(FIFO_DEPTH));

    // --------------------
    // storage
    // --------------------
    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= push_req;
        end
    end

    // --------------------
    // pointers and count
    // --------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;  // wraps, depth is a power of two
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;  // idle or push with pop
            endcase
        end
    end

endmodule

// File: source/ddr2_req_capture.sv
`timescale 1ns/1ns

module ddr2_req_capture import ddr2_pkg::*; (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      req_valid,
    input  logic                      req_write,
    input  logic [HOST_ADDR_BITS-1:0] req_addr,
    input  logic [3:0]                req_beats_m1,
    input  logic                      full,
    output logic                      req_ready,
    output logic                      push,
    output ddr2_req_t                 push_req
);

    logic      hold_full;  // holding register occupied
    ddr2_req_t hold_req;

    assign req_ready = ~hold_full;
    assign push      = hold_full & ~full;  // wait here while the queue is full
    assign push_req  = hold_req;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hold_full <= 1'b0;
        end else if (req_valid && req_ready) begin
            hold_full <= 1'b1;
        end else if (push) begin
            hold_full <= 1'b0;
        end
    end

    // split flat address, low two column bits dropped
    always_ff @(posedge clk) begin
        if (req_valid && req_ready) begin
            hold_req.is_write <= req_write;
            hold_req.ba       <= req_addr[HOST_ADDR_BITS-1 -: BA_BITS];
            hold_req.row      <= req_addr[COL_BITS +: ROW_BITS];
            hold_req.col_q    <= req_addr[COL_BITS-1:2];
            hold_req.beats_m1 <= req_beats_m1;
        end
    end

endmodule

// File: source/ddr2_pkg.sv
package ddr2_pkg;

    // --------------------
    // address geometry
    // --------------------
    localparam int BA_BITS        = 3;
    localparam int ROW_BITS       = 14;
    localparam int COL_BITS       = 10;
    localparam int ADDR_BITS      = 14;
    localparam int HOST_ADDR_BITS = BA_BITS + ROW_BITS + COL_BITS;  // bank, row, column

    // --------------------
    // timing in clk cycles, 5 ns memory clock
    // --------------------
    localparam int T_RCD     = 3;
    localparam int T_RP      = 3;
    localparam int T_RFC     = 26;
    localparam int T_REFI    = 1560;
    localparam int T_WR      = 3;
    localparam int T_RTP     = 2;
    localparam int CL        = 3;
    localparam int WL        = CL - 1;
    localparam int WR_TO_PRE = WL + 2 + T_WR;  // last data beat, then write recovery
    localparam int RD_TO_PRE = 2 + T_RTP;

    localparam int FIFO_DEPTH = 4;
    localparam int A10_ALL    = 10;  // all banks on PRE, auto precharge on column cmds

    // {cs_n, ras_n, cas_n, we_n}
    typedef enum logic [3:0] {
        NOP   = 4'b0111,
        ACT   = 4'b0011,
        WRITE = 4'b0100,
        READ  = 4'b0101,
        PRE   = 4'b0010,
        AREF  = 4'b0001
    } ddr2_cmd_e;

    typedef struct packed {
        logic                  is_write;
        logic [BA_BITS-1:0]    ba;
        logic [ROW_BITS-1:0]   row;
        logic [COL_BITS-3:0]   col_q;     // column in four-word units
        logic [3:0]            beats_m1;  // bursts minus one
    } ddr2_req_t;

    typedef struct packed {
        logic [ADDR_BITS-A10_ALL-2:0] spare;
        logic                         a10;
        logic [A10_ALL-1:0]           col;
    } ddr2_col_addr_t;

    // one address word, row view for ACT and column view for WRITE/READ/PRE
    typedef union packed {
        logic [ROW_BITS-1:0] as_row;
        ddr2_col_addr_t      as_col;
    } ddr2_addr_u;

    typedef struct packed {
        ddr2_cmd_e          cmd;
        logic [BA_BITS-1:0] ba;
        ddr2_addr_u         addr;
    } ddr2_bus_t;

endpackage
